/* verilog/tlcs_pkg.sv */
package tlcs_pkg;

    typedef logic [31:0] op_win_t;      // Four opcode bytes, first byte lowest
    typedef logic [2:0]  byte_cnt_t;    // Bytes consumed per cycle
    typedef logic [5:0]  alu_op_t;
    typedef logic [31:0] imm_t;
    typedef logic [7:0]  reg_code_t;    // Full register code
    typedef logic [2:0]  size_we_t;     // One-hot byte, word, long
    typedef logic [3:0]  cond_t;
    typedef logic [7:0]  flags_t;

    // Micro-op kinds
    typedef enum logic [2:0] {
        act_alu,
        act_flag,
        act_jr,
        act_incf,
        act_decf
    } act_t;

    typedef enum logic {
        st_issue,
        st_bubble                       // Dead cycle after a taken jump
    } seq_state_t;

    // Single-byte opcodes matched exactly
    localparam logic [7:0] OP_NOP  = 8'h00;
    localparam logic [7:0] OP_INCF = 8'h0c;
    localparam logic [7:0] OP_DECF = 8'h0d;

    localparam alu_op_t ALU_NOP  = 6'd0;
    localparam alu_op_t ALU_MOVE = 6'd1;
    localparam alu_op_t ALU_RCF  = 6'd2;
    localparam alu_op_t ALU_SCF  = 6'd3;
    localparam alu_op_t ALU_CCF  = 6'd4;
    localparam alu_op_t ALU_ZCF  = 6'd5;

    // Flag bit positions
    localparam int FS = 7;
    localparam int FZ = 6;
    localparam int FV = 2;
    localparam int FC = 0;

    localparam int QUEUE_DEPTH = 4;

    localparam imm_t JR_LEN = 32'd2;    // Offset is relative to the next opcode

endpackage

/* verilog/uop_if.sv */
`timescale 1ns/1ps

interface uop_if;
    import tlcs_pkg::*;

    logic      strobe;                  // Entry present
    logic      stall;                   // Receiver cannot take it
    act_t      act;
    alu_op_t   alu_op;
    imm_t      alu_imm;
    reg_code_t regs_dst;
    size_we_t  regs_we;
    cond_t     cond;

    modport source (
        output strobe, act, alu_op, alu_imm, regs_dst, regs_we, cond,
        input  stall
    );

    modport sink (
        input  strobe, act, alu_op, alu_imm, regs_dst, regs_we, cond,
        output stall
    );

endinterface

/* verilog/op_decoder.sv */
`timescale 1ns/1ps

module op_decoder (
    input  tlcs_pkg::op_win_t   op,
    input  logic                op_ok,
    output tlcs_pkg::byte_cnt_t fetched,
    uop_if.source               link
);
    import tlcs_pkg::*;

    byte_cnt_t len;                     // Instruction length
    logic      has_uop;

    // Short register number to full register code
    function automatic reg_code_t expand_reg(input logic [2:0] r, input logic word);
        reg_code_t code;
        if (!word) begin
            code = {4'he, r[2:1], 1'b0, ~r[0]};
        end else if (r[2]) begin
            code = {4'hf, r[1:0], 2'b00};
        end else begin
            code = {4'he, r[1:0], 2'b00};
        end
        return code;
    endfunction

    always_comb begin
        len           = 3'd1;
        has_uop       = 1'b0;
        link.act      = act_alu;
        link.alu_op   = ALU_NOP;
        link.alu_imm  = '0;
        link.regs_dst = '0;
        link.regs_we  = '0;
        link.cond     = '0;
        priority casez (op[7:0])
            OP_NOP: begin
                len = 3'd1;
            end
            8'b0010_0???: begin // LD R,# byte
                has_uop       = 1'b1;
                len           = 3'd2;
                link.act      = act_alu;
                link.alu_op   = ALU_MOVE;
                link.alu_imm  = {24'd0, op[15:8]};
                link.regs_dst = expand_reg(op[2:0], 1'b0);
                link.regs_we  = 3'b001;
            end
            8'b0011_0???: begin // LD R,# word
                has_uop       = 1'b1;
                len           = 3'd3;
                link.act      = act_alu;
                link.alu_op   = ALU_MOVE;
                link.alu_imm  = {16'd0, op[23:8]};
                link.regs_dst = expand_reg(op[2:0], 1'b1);
                link.regs_we  = 3'b010;
            end
            8'b0001_00??: begin // RCF SCF CCF ZCF
                has_uop  = 1'b1;
                len      = 3'd1;
                link.act = act_flag;
                case (op[1:0])
                    2'd0: link.alu_op = ALU_RCF;
                    2'd1: link.alu_op = ALU_SCF;
                    2'd2: link.alu_op = ALU_CCF;
                    default: link.alu_op = ALU_ZCF;
                endcase
            end
            OP_INCF: begin
                has_uop  = 1'b1;
                len      = 3'd1;
                link.act = act_incf;
            end
            OP_DECF: begin
                has_uop  = 1'b1;
                len      = 3'd1;
                link.act = act_decf;
            end
            8'b0110_????: begin // JR cc,d8
                has_uop      = 1'b1;
                len          = 3'd2;
                link.act     = act_jr;
                link.cond    = op[3:0];
                link.alu_imm = {{24{op[15]}}, op[15:8]} + JR_LEN;
            end
            default: begin
                len = 3'd1; // Unknown byte skipped
            end
        endcase
    end

    assign link.strobe = op_ok & has_uop;
    assign fetched     = (op_ok && !link.stall) ? len : 3'd0;  // Hold window while queue full

endmodule

/* verilog/uop_queue.sv */
`timescale 1ns/1ps

module uop_queue (
    input  logic  clk,
    input  logic  rst,
    uop_if.sink   in_link,
    uop_if.source out_link
);
    import tlcs_pkg::*;

    act_t      act_q    [QUEUE_DEPTH];
    alu_op_t   alu_op_q [QUEUE_DEPTH];
    imm_t      imm_q    [QUEUE_DEPTH];
    reg_code_t dst_q    [QUEUE_DEPTH];
    size_we_t  we_q     [QUEUE_DEPTH];
    cond_t     cond_q   [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] count;
    logic                             push;
    logic                             pop;

    assign in_link.stall   = (count == QUEUE_DEPTH);
    assign push            = in_link.strobe & ~in_link.stall;
    assign out_link.strobe = (count != 0);
    assign pop             = out_link.strobe & ~out_link.stall;

    // Head entry
    assign out_link.act      = act_q[rd_ptr];
    assign out_link.alu_op   = alu_op_q[rd_ptr];
    assign out_link.alu_imm  = imm_q[rd_ptr];
    assign out_link.regs_dst = dst_q[rd_ptr];
    assign out_link.regs_we  = we_q[rd_ptr];
    assign out_link.cond     = cond_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            act_q[wr_ptr]    <= in_link.act;
            alu_op_q[wr_ptr] <= in_link.alu_op;
            imm_q[wr_ptr]    <= in_link.alu_imm;
            dst_q[wr_ptr]    <= in_link.regs_dst;
            we_q[wr_ptr]     <= in_link.regs_we;
            cond_q[wr_ptr]   <= in_link.cond;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

/* verilog/issue_seq.sv */
`timescale 1ns/1ps

module issue_seq (
    input  logic                clk,
    input  logic                rst,
    input  tlcs_pkg::flags_t    flags,
    uop_if.sink                 link,
    output tlcs_pkg::alu_op_t   alu_op,
    output tlcs_pkg::imm_t      alu_imm,
    output logic                alu_smux,
    output tlcs_pkg::size_we_t  regs_we,
    output tlcs_pkg::reg_code_t regs_dst,
    output logic                flag_we,
    output logic                pc_rel,
    output logic                inc_rfp,
    output logic                dec_rfp
);
    import tlcs_pkg::*;

    seq_state_t state;
    seq_state_t nx_state;
    logic       take;
    logic       jr_taken;

    // Jump condition table
    function automatic logic cond_ok(input cond_t cc, input flags_t f);
        logic ok;
        case (cc)
            4'd0:  ok = 1'b0;
            4'd1:  ok = f[FS] ^ f[FV];               // Signed less
            4'd2:  ok = f[FZ] | (f[FS] ^ f[FV]);     // Signed less or equal
            4'd3:  ok = f[FZ] | f[FC];               // Unsigned less or equal
            4'd4:  ok = f[FV];
            4'd5:  ok = f[FS];
            4'd6:  ok = f[FZ];
            4'd7:  ok = f[FC];
            4'd8:  ok = 1'b1;
            4'd9:  ok = ~(f[FS] ^ f[FV]);
            4'd10: ok = ~(f[FZ] | (f[FS] ^ f[FV]));
            4'd11: ok = ~(f[FZ] | f[FC]);
            4'd12: ok = ~f[FV];
            4'd13: ok = ~f[FS];
            4'd14: ok = ~f[FZ];
            default: ok = ~f[FC];
        endcase
        return ok;
    endfunction

    assign link.stall = (state == st_bubble);
    assign take       = link.strobe & ~link.stall;
    assign jr_taken   = take && (link.act == act_jr) && cond_ok(link.cond, flags);

    always_comb begin
        nx_state = st_issue;
        if (state == st_issue && jr_taken) nx_state = st_bubble;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_issue;
            alu_op   <= ALU_NOP;
            alu_smux <= 1'b0;
            regs_we  <= '0;
            flag_we  <= 1'b0;
            pc_rel   <= 1'b0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
        end else begin
            state    <= nx_state;
            alu_op   <= ALU_NOP;                // Strobes last one cycle
            alu_smux <= 1'b0;
            regs_we  <= '0;
            flag_we  <= 1'b0;
            pc_rel   <= jr_taken;
            inc_rfp  <= take && (link.act == act_incf);
            dec_rfp  <= take && (link.act == act_decf);
            if (take && link.act == act_alu) begin
                alu_op   <= link.alu_op;
                alu_smux <= 1'b1;               // Immediate as ALU source
                regs_we  <= link.regs_we;
            end
            if (take && link.act == act_flag) begin
                alu_op  <= link.alu_op;
                flag_we <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && (link.act == act_alu || jr_taken)) alu_imm <= link.alu_imm;
        if (take && link.act == act_alu) regs_dst <= link.regs_dst;
    end

endmodule

/* verilog/tlcs_ctrl.sv */
`timescale 1ns/1ps

module tlcs_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  tlcs_pkg::op_win_t   op,
    input  logic                op_ok,
    input  tlcs_pkg::flags_t    flags,
    output tlcs_pkg::byte_cnt_t fetched,
    output tlcs_pkg::alu_op_t   alu_op,
    output tlcs_pkg::imm_t      alu_imm,
    output logic                alu_smux,
    output tlcs_pkg::size_we_t  regs_we,
    output tlcs_pkg::reg_code_t regs_dst,
    output logic                flag_we,
    output logic                pc_rel,
    output logic                inc_rfp,
    output logic                dec_rfp
);

    uop_if dec_link ();                 // Decoder to queue
    uop_if iss_link ();                 // Queue to sequencer

    op_decoder op_decoder_i (
        .op      (op),
        .op_ok   (op_ok),
        .fetched (fetched),
        .link    (dec_link.source)
    );

    uop_queue uop_queue_i (
        .clk      (clk),
        .rst      (rst),
        .in_link  (dec_link.sink),
        .out_link (iss_link.source)
    );

    issue_seq issue_seq_i (
        .clk      (clk),
        .rst      (rst),
        .flags    (flags),
        .link     (iss_link.sink),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .alu_smux (alu_smux),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .flag_we  (flag_we),
        .pc_rel   (pc_rel),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp)
    );

endmodule

/* bench/tlcs_ctrl_tb.sv */
`timescale 1ns/1ps

module tlcs_ctrl_tb;
    import tlcs_pkg::*;

    typedef logic [52:0] ev_t;          // Kind, smux, alu_op, imm, dst, we

    localparam logic [2:0] K_ALU  = 3'd1;
    localparam logic [2:0] K_FLAG = 3'd2;
    localparam logic [2:0] K_JR   = 3'd3;
    localparam logic [2:0] K_INCF = 3'd4;
    localparam logic [2:0] K_DECF = 3'd5;

    logic      clk = 1'b0;
    logic      rst;
    op_win_t   op;
    logic      op_ok;
    flags_t    flags;
    byte_cnt_t fetched;
    alu_op_t   alu_op;
    imm_t      alu_imm;
    logic      alu_smux;
    size_we_t  regs_we;
    reg_code_t regs_dst;
    logic      flag_we;
    logic      pc_rel;
    logic      inc_rfp;
    logic      dec_rfp;

    logic [7:0]  prog [256];            // Program bytes
    int          prog_len;
    ev_t         exp_q [$];
    logic [31:0] rng;
    int          errors;
    int          tests_run;
    int          tests_failed;
    ev_t         obs_ev;
    int          nstb;

    tlcs_ctrl tlcs_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_ok    (op_ok),
        .flags    (flags),
        .fetched  (fetched),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .alu_smux (alu_smux),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .flag_we  (flag_we),
        .pc_rel   (pc_rel),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Length of the instruction at pos and the event it should cause
    function automatic int ref_decode(input int pos, input flags_t f, output ev_t ev,
                                      output logic has_ev);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [2:0] r;
        logic [7:0] bdst;
        logic [7:0] wdst;
        logic       base;
        int         len;
        b0 = prog[pos];
        b1 = prog[pos+1];
        b2 = prog[pos+2];
        r = b0[2:0];
        bdst = 8'he0 + 8'(4 * r[2:1]) + 8'(!r[0]);
        wdst = (r < 3'd4) ? 8'he0 + 8'(4 * r) : 8'hf0 + 8'(4 * (r - 3'd4));
        ev = '0;
        has_ev = 1'b1;
        len = 1;
        if (b0 >= 8'h20 && b0 <= 8'h27) begin
            len = 2;
            ev = {K_ALU, 1'b1, ALU_MOVE, {24'd0, b1}, bdst, 3'b001};
        end else if (b0 >= 8'h30 && b0 <= 8'h37) begin
            len = 3;
            ev = {K_ALU, 1'b1, ALU_MOVE, {16'd0, b2, b1}, wdst, 3'b010};
        end else if (b0 >= 8'h10 && b0 <= 8'h13) begin
            ev = {K_FLAG, 1'b0, alu_op_t'(ALU_RCF + b0[1:0]), 32'd0, 8'd0, 3'd0};
        end else if (b0 == 8'h0c) begin
            ev = {K_INCF, 1'b0, ALU_NOP, 32'd0, 8'd0, 3'd0};
        end else if (b0 == 8'h0d) begin
            ev = {K_DECF, 1'b0, ALU_NOP, 32'd0, 8'd0, 3'd0};
        end else if (b0[7:4] == 4'h6) begin
            len = 2;
            case (b0[2:0])
                3'd0: base = 1'b0;
                3'd1: base = f[FS] ^ f[FV];
                3'd2: base = f[FZ] | (f[FS] ^ f[FV]);
                3'd3: base = f[FZ] | f[FC];
                3'd4: base = f[FV];
                3'd5: base = f[FS];
                3'd6: base = f[FZ];
                default: base = f[FC];
            endcase
            has_ev = base ^ b0[3];      // Upper eight codes invert the lower eight
            ev = {K_JR, 1'b0, ALU_NOP, {{24{b1[7]}}, b1} + 32'd2, 8'd0, 3'd0};
        end else begin
            has_ev = 1'b0;              // NOP or unknown byte
        end
        return len;
    endfunction

    task automatic build_expected(input flags_t f);
        int   pos;
        ev_t  ev;
        logic has;
        exp_q.delete();
        pos = 0;
        while (pos < prog_len) begin
            pos += ref_decode(pos, f, ev, has);
            if (has) exp_q.push_back(ev);
        end
    endtask

    // Compare every strobe cycle with the head of the expected list
    always @(negedge clk) begin
        if (!rst) begin
            nstb = int'(regs_we != '0) + int'(flag_we) + int'(pc_rel) + int'(inc_rfp)
                   + int'(dec_rfp);
            obs_ev = {3'd0, alu_smux, alu_op, 32'd0, 8'd0, regs_we};
            if (regs_we != '0) obs_ev = {K_ALU, alu_smux, alu_op, alu_imm, regs_dst, regs_we};
            else if (flag_we) obs_ev[52:50] = K_FLAG;
            else if (pc_rel) obs_ev = {K_JR, alu_smux, alu_op, alu_imm, 8'd0, regs_we};
            else if (inc_rfp) obs_ev[52:50] = K_INCF;
            else if (dec_rfp) obs_ev[52:50] = K_DECF;
            if (nstb > 0) begin
                assert (nstb == 1) else begin
                    $display("%0t: more than one strobe active in the same cycle", $time);
                    errors++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("%0t: strobe seen although no further event was expected", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    assert (obs_ev == exp_q[0]) else begin
                        $display("FAIL %0t: event %h, expected %h", $time, obs_ev, exp_q[0]);
                        errors++;
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (regs_we == '0 && !flag_we && !pc_rel && !inc_rfp && !dec_rfp && !alu_smux
                    && fetched == '0 && alu_op == ALU_NOP)
            else begin
                $display("FAIL %0t: outputs not idle, fetched %0d alu_op %0d", $time, fetched,
                         alu_op);
                errors++;
            end
        end
    endtask

    task automatic clear_prog();
        foreach (prog[i]) prog[i] = 8'h00;
        prog_len = 0;
    endtask

    task automatic put_byte(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len++;
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // Streams the program through the window from 1 ns after a rising edge
    task automatic run_program(input string name, input flags_t f, input logic gaps);
        int   ptr;
        int   step;
        int   sum;
        int   cycles;
        int   err0;
        ev_t  ev;
        logic has;
        ptr = 0;
        sum = 0;
        cycles = 0;
        err0 = errors;
        flags = f;
        build_expected(f);
        while (ptr < prog_len && cycles < 4 * prog_len + 200) begin
            op = {prog[ptr+3], prog[ptr+2], prog[ptr+1], prog[ptr]};
            rng = xorshift(rng);
            op_ok = !gaps || (rng[1:0] != 2'b00);
            @(negedge clk);
            step = int'(fetched);
            if (step != 0) begin
                assert (step == ref_decode(ptr, f, ev, has)) else begin
                    $display("FAIL %0t: fetched %0d at byte %0d", $time, step, ptr);
                    errors++;
                end
            end
            sum += step;
            ptr += step;
            @(posedge clk);
            #1;
            cycles++;
        end
        op_ok = 1'b0;
        if (ptr < prog_len) begin
            $display("%0t: timed out streaming %s at byte %0d", $time, name, ptr);
            errors++;
        end
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%0t: timed out with %0d events never seen", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (6) @(posedge clk);      // Room for stray strobes
        #1;
        assert (sum == prog_len) else begin
            $display("FAIL %0t: fetched total %0d, program length %0d", $time, sum, prog_len);
            errors++;
        end
        report_test(name, err0);
    endtask

    initial begin
        int         err0;
        int         k;
        logic [7:0] op0;
        ev_t        ev;
        logic       has;
        flags_t     jf;
        rst = 1'b1;
        op = '0;
        op_ok = 1'b0;
        flags = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        prog_len = 0;
        rng = 32'ha7a1e70e;

        err0 = errors;
        check_quiet(4);
        @(posedge clk);
        #1;
        rst = 1'b0;
        check_quiet(8);
        @(posedge clk);
        #1;
        report_test("reset_idle", err0);

        clear_prog();
        for (k = 0; k < 8; k++) begin
            rng = xorshift(rng);
            put_byte(8'h20 + 8'(k));
            put_byte(rng[7:0]);
            put_byte(8'h30 + 8'(k));
            put_byte(rng[15:8]);
            put_byte(rng[23:16]);
        end
        run_program("ld_imm", 8'h00, 1'b0);

        clear_prog();
        put_byte(8'h10);
        put_byte(8'h00);
        put_byte(8'h11);
        put_byte(8'h40);                // Unknown bytes in between
        put_byte(8'h12);
        put_byte(8'hff);
        put_byte(8'h13);
        put_byte(8'h14);
        run_program("flag_ops", 8'h00, 1'b0);

        for (k = 0; k < 2; k++) begin
            clear_prog();
            rng = xorshift(rng);
            jf = rng[31:24];
            for (int c = 0; c < 16; c++) begin
                rng = xorshift(rng);
                put_byte(8'h60 + 8'(c));
                put_byte(rng[7:0]);
            end
            run_program("jr_cond", jf, 1'b0);
        end

        clear_prog();
        put_byte(8'h0c);
        put_byte(8'h00);
        put_byte(8'h0d);
        put_byte(8'h0d);
        put_byte(8'h0c);
        put_byte(8'h0d);
        run_program("incf_decf", 8'h00, 1'b0);

        clear_prog();
        while (prog_len < 180) begin
            rng = xorshift(rng);
            case (rng[2:0])
                3'd0: op0 = 8'h20 | 8'(rng[10:8]);
                3'd1: op0 = 8'h30 | 8'(rng[10:8]);
                3'd2: op0 = 8'h10 | 8'(rng[9:8]);
                3'd3: op0 = 8'h0c | 8'(rng[8]);
                3'd4, 3'd5: op0 = 8'h60 | 8'(rng[11:8]);
                3'd6: op0 = 8'h00;
                default: op0 = rng[15:8];   // Any byte at all
            endcase
            prog[prog_len] = op0;
            prog[prog_len+1] = rng[23:16];
            prog[prog_len+2] = rng[31:24];
            prog_len += ref_decode(prog_len, 8'h00, ev, has);
        end
        rng = xorshift(rng);
        run_program("random_long", rng[7:0], 1'b1);

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tlcs_ctrl.f */
verilog/tlcs_pkg.sv
verilog/uop_if.sv
verilog/op_decoder.sv
verilog/uop_queue.sv
verilog/issue_seq.sv
verilog/tlcs_ctrl.sv
bench/tlcs_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the tlcs_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tlcs_ctrl_tb -f tlcs_ctrl.f -o tlcs_ctrl_sim

./obj_dir/tlcs_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
grep -q "all tests passed" sim.log
echo "simulation passed"
